// File: dcache.f
source/dcache_pkg.sv
source/dcache_decode.sv
source/dcache_data.sv
source/dcache_ctrl.sv
source/dcache_load_align.sv
source/dcache_top.sv
tb/dcache_chk.sv
tb/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - source/dcache_pkg.sv
      - source/dcache_decode.sv
      - source/dcache_data.sv
      - source/dcache_ctrl.sv
      - source/dcache_load_align.sv
      - source/dcache_top.sv
  - target: test
    files:
      - tb/dcache_chk.sv
      - tb/dcache_tb.sv

// File: tb/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

  localparam int INDEX_W     = 6;
  localparam int CYCLE_LIMIT = 4000;  // roughly 80 accesses times worst miss latency plus margin
  localparam logic [31:0] ALIAS = 32'd1 << (INDEX_W + 4);  // same index with the next tag

  logic                 clk = 1'b0;
  logic                 reset = 1'b1;
  logic                 req = 1'b0;
  dcache_pkg::cpu_req_t cpu_req = '0;
  logic                 mem_rd_valid = 1'b0;
  logic [127:0]         mem_rd_line = '0;
  logic                 busy;
  logic                 rvalid;
  logic [63:0]          rdata;
  logic                 mem_rd_req;
  logic [31:0]          mem_rd_addr;
  logic                 mem_wr;
  logic [31:0]          mem_wr_addr;
  logic [63:0]          mem_wr_data;
  logic [7:0]           mem_wr_mask;

  logic [63:0] mem_words [logic [28:0]];  // keyed by 8-byte word address
  logic [31:0] lfsr = 32'ha8d2_9e36;
  int          cycles = 0;
  int          rd_count = 0;
  int          wr_count = 0;
  int          delay;
  int          lat;
  logic [31:0] rd_base;
  logic [31:0] last_rd_addr;
  logic [31:0] last_wr_addr;
  logic [63:0] last_wr_data;
  logic [7:0]  last_wr_mask;
  logic [63:0] rd_data;
  logic [63:0] word;

  dcache_top #(.INDEX_W(INDEX_W)) dut (.*);

  initial begin
    forever #4 clk = ~clk;
  end

  function automatic logic [63:0] next_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [63:0] read_word(logic [31:0] a);
    logic [31:0] w;
    w = {a[31:3], 3'b000};
    if (mem_words.exists(a[31:3])) return mem_words[a[31:3]];
    return {~w ^ {w[15:0], w[31:16]}, w ^ 32'h3c5a_96e1};  // untouched memory
  endfunction

  function automatic logic [63:0] expect_load(logic [31:0] a, dcache_pkg::size_e sz, logic u);
    logic [63:0] v;
    int          nb;
    nb = 1 << sz;
    v  = read_word(a) >> (8 * a[2:0]);
    for (int i = 8 * nb; i < 64; i++)
      v[i] = u ? 1'b0 : v[8 * nb - 1];
    return v;
  endfunction

  function automatic logic [7:0] byte_mask(logic [31:0] a, dcache_pkg::size_e sz);
    logic [7:0] m;
    for (int b = 0; b < 8; b++)
      m[b] = (b >= a[2:0]) && (b < a[2:0] + (1 << sz));
    return m;
  endfunction

  task automatic check(string name, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one request that waits for rvalid or for busy to drop
  task automatic access(logic st, dcache_pkg::size_e sz, logic u, logic [31:0] a,
                        logic [63:0] wd);
    int t0;
    @(posedge clk);
    req     <= 1'b1;
    cpu_req <= '{we: st, size: sz, uns: u, addr: a, wdata: wd};
    @(posedge clk);
    while (busy) @(posedge clk);
    t0 = cycles;
    req <= 1'b0;
    @(posedge clk);
    while (st ? busy : !rvalid) @(posedge clk);
    rd_data = rdata;
    lat     = cycles - t0;
  endtask

  task automatic load_check(string name, logic [31:0] a, dcache_pkg::size_e sz, logic u,
                            int misses);
    int rd0;
    rd0 = rd_count;
    access(1'b0, sz, u, a, '0);
    check(name, expect_load(a, sz, u), rd_data);
    check({name, " refills"}, misses, rd_count - rd0);
  endtask

  task automatic store_check(string name, logic [31:0] a, dcache_pkg::size_e sz,
                             logic [63:0] wd);
    int          rd0;
    int          wr0;
    logic [7:0]  m;
    logic [63:0] keep;
    rd0 = rd_count;
    wr0 = wr_count;
    m   = byte_mask(a, sz);
    for (int b = 0; b < 8; b++)
      keep[8*b +: 8] = {8{m[b]}};
    access(1'b1, sz, 1'b0, a, wd);
    check({name, " writes"}, 1, wr_count - wr0);
    check({name, " refills"}, 0, rd_count - rd0);
    check({name, " addr"}, {a[31:3], 3'b000}, last_wr_addr);
    check({name, " mask"}, m, last_wr_mask);
    check({name, " data"}, (wd << (8 * a[2:0])) & keep, last_wr_data & keep);
  endtask

  task automatic reset_then_first_miss();
    @(posedge clk);
    check("reset outputs", 0, {busy, rvalid, mem_rd_req, mem_wr});
    load_check("first load miss", 32'h1008, dcache_pkg::size_double, 1'b0, 1);
    check("refill addr", 32'h1000, last_rd_addr);
  endtask

  task automatic second_load_hits();
    load_check("load hit", 32'h1004, dcache_pkg::size_word, 1'b0, 0);
    check("load hit latency", 4, lat);
    check("load hit busy", 0, busy);
  endtask

  task automatic loads_of_every_size();
    for (int s = 0; s < 4; s++)
      for (int off = 0; off < 16; off += (1 << s))
        for (int u = 0; u < 2; u++)
          load_check($sformatf("load size %0d off %0d uns %0d", s, off, u), 32'h2000 + off,
                     dcache_pkg::size_e'(s), u[0], (s == 0 && off == 0 && u == 0) ? 1 : 0);
  endtask

  task automatic store_hits_merge();
    logic [31:0] a;
    load_check("store line fill", 32'h3000, dcache_pkg::size_double, 1'b0, 1);
    for (int s = 0; s < 4; s++) begin
      a = 32'h3000 + 8 * (s % 2) + 8 - (1 << s);  // alternates low and high word
      store_check($sformatf("store hit size %0d", s), a, dcache_pkg::size_e'(s), next_bits(64));
      load_check($sformatf("merge size %0d", s), {a[31:3], 3'b000}, dcache_pkg::size_double,
                 1'b0, 0);
    end
  endtask

  task automatic store_miss_no_allocate();
    logic [63:0] wd;
    wd = next_bits(64);
    store_check("store miss", 32'h4008, dcache_pkg::size_word, wd);
    load_check("reload after store miss", 32'h4008, dcache_pkg::size_word, 1'b1, 1);
    check("store miss value", wd[31:0], rd_data);
  endtask

  task automatic conflict_eviction();
    for (int i = 0; i < 4; i++)
      load_check($sformatf("conflict pass %0d", i), 32'h5020 + (i % 2) * ALIAS,
                 dcache_pkg::size_double, 1'b0, 1);
  endtask

  // memory writes and strobe counters
  always @(posedge clk) begin
    if (mem_wr) begin
      word = read_word(mem_wr_addr);
      for (int b = 0; b < 8; b++) begin
        if (mem_wr_mask[b]) begin
          word[8*b +: 8] = mem_wr_data[8*b +: 8];
        end
      end
      mem_words[mem_wr_addr[31:3]] = word;
      wr_count++;
      last_wr_addr = mem_wr_addr;
      last_wr_data = mem_wr_data;
      last_wr_mask = mem_wr_mask;
    end
  end

  // refill responder with 1 to 8 cycles of delay
  always begin
    @(posedge clk);
    if (mem_rd_req) begin
      rd_count++;
      last_rd_addr = mem_rd_addr;
      rd_base      = mem_rd_addr;
      delay        = 1 + int'(next_bits(3));
      repeat (delay - 1) @(posedge clk);
      mem_rd_line  <= {read_word(rd_base + 8), read_word(rd_base)};
      mem_rd_valid <= 1'b1;
      @(posedge clk);
      mem_rd_valid <= 1'b0;
    end
  end

  always @(posedge clk) begin
    if (dut.u_chk.fails != 0) begin
      $display("a port assertion failed, the run stops here");
      $display("SIMULATION FAILED");
      $fatal(1, "assertion failure");
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    reset_then_first_miss();
    second_load_hits();
    loads_of_every_size();
    store_hits_merge();
    store_miss_no_allocate();
    conflict_eviction();
    repeat (5) @(posedge clk);
    if (dut.u_chk.fails == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures in the port checker", dut.u_chk.fails);
      $display("SIMULATION FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// File: tb/dcache_chk.sv
`timescale 1ns/1ps

module dcache_chk (
  input logic                 clk,
  input logic                 reset,
  input logic                 req,
  input logic                 busy,
  input logic                 rvalid,
  input logic                 mem_rd_req,
  input logic                 mem_wr,
  input dcache_pkg::cpu_req_t cpu_req
);

  int unsigned fails = 0;

  function automatic logic size_aligned(logic [2:0] low, dcache_pkg::size_e size);
    case (size)
      dcache_pkg::size_byte: return 1'b1;
      dcache_pkg::size_half: return low[0] == 1'b0;
      dcache_pkg::size_word: return low[1:0] == 2'b00;
      default:               return low == 3'b000;
    endcase
  endfunction

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(mem_rd_req && mem_wr))
    else begin
      $error("memory read request while a memory write is pending");
      fails++;
    end

  // load result and a new acceptance never share a cycle
  a_rvalid_accept: assert property (@(posedge clk) disable iff (reset) !(rvalid && req && !busy))
    else begin
      $error("rvalid in the same cycle as an accepted request");
      fails++;
    end

  a_aligned: assert property (@(posedge clk) disable iff (reset)
    (req && !busy) |-> size_aligned(cpu_req.addr[2:0], cpu_req.size))
    else begin
      $error("accepted request is misaligned for its size");
      fails++;
    end

endmodule

bind dcache_top dcache_chk u_chk (
  .clk        (clk),
  .reset      (reset),
  .req        (req),
  .busy       (busy),
  .rvalid     (rvalid),
  .mem_rd_req (mem_rd_req),
  .mem_wr     (mem_wr),
  .cpu_req    (cpu_req)
);

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
  parameter int INDEX_W = 6  // 64 lines
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req,
  input  dcache_pkg::cpu_req_t                cpu_req,
  input  logic                                mem_rd_valid,
  input  logic [8*dcache_pkg::LINE_BYTES-1:0] mem_rd_line,
  output logic                                busy,
  output logic                                rvalid,
  output logic [dcache_pkg::XLEN-1:0]         rdata,
  output logic                                mem_rd_req,
  output logic [dcache_pkg::ADDR_W-1:0]       mem_rd_addr,
  output logic                                mem_wr,
  output logic [dcache_pkg::ADDR_W-1:0]       mem_wr_addr,
  output logic [dcache_pkg::XLEN-1:0]         mem_wr_data,
  output logic [dcache_pkg::XLEN/8-1:0]       mem_wr_mask
);

  logic                                dec_valid;
  dcache_pkg::dec_req_t                dec_req;
  logic                                ld_valid;
  logic [8*dcache_pkg::LINE_BYTES-1:0] ld_line;
  dcache_pkg::dec_req_t                ld_req;
  logic                                accept;

  assign accept = ~busy;

  dcache_decode #(
    .INDEX_W (INDEX_W)
  ) u_decode (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .accept    (accept),
    .cpu_req   (cpu_req),
    .dec_valid (dec_valid),
    .dec_req   (dec_req)
  );

  dcache_ctrl #(
    .INDEX_W (INDEX_W)
  ) u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .dec_valid    (dec_valid),
    .dec_req      (dec_req),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_line  (mem_rd_line),
    .busy         (busy),
    .mem_rd_req   (mem_rd_req),
    .mem_rd_addr  (mem_rd_addr),
    .mem_wr       (mem_wr),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_mask  (mem_wr_mask),
    .ld_valid     (ld_valid),
    .ld_line      (ld_line),
    .ld_req       (ld_req)
  );

  dcache_load_align u_align (
    .clk      (clk),
    .reset    (reset),
    .ld_valid (ld_valid),
    .ld_line  (ld_line),
    .ld_req   (ld_req),
    .rvalid   (rvalid),
    .rdata    (rdata)
  );

endmodule

// File: source/dcache_load_align.sv
`timescale 1ns/1ps

module dcache_load_align (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                ld_valid,
  input  logic [8*dcache_pkg::LINE_BYTES-1:0] ld_line,
  input  dcache_pkg::dec_req_t                ld_req,
  output logic                                rvalid,
  output logic [dcache_pkg::XLEN-1:0]         rdata
);

  localparam int XLEN = dcache_pkg::XLEN;

  logic [8*dcache_pkg::LINE_BYTES-1:0] shifted;
  logic [XLEN-1:0]                     ext;

  // addressed byte moved down to bit 0
  assign shifted = ld_line >> {ld_req.offset, 3'b000};

  always_comb begin
    case (ld_req.size)
      dcache_pkg::size_byte: begin
        ext = ld_req.uns ? {{(XLEN-8){1'b0}}, shifted[7:0]}
                         : {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      dcache_pkg::size_half: begin
        ext = ld_req.uns ? {{(XLEN-16){1'b0}}, shifted[15:0]}
                         : {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      dcache_pkg::size_word: begin
        ext = ld_req.uns ? {{(XLEN-32){1'b0}}, shifted[31:0]}
                         : {{(XLEN-32){shifted[31]}}, shifted[31:0]};
      end
      default: ext = shifted[XLEN-1:0];  // double, nothing to extend
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= ld_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_valid) begin
      rdata <= ext;
    end
  end

endmodule

// File: source/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
  parameter int INDEX_W = 6
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                dec_valid,
  input  dcache_pkg::dec_req_t                dec_req,
  input  logic                                mem_rd_valid,
  input  logic [8*dcache_pkg::LINE_BYTES-1:0] mem_rd_line,
  output logic                                busy,
  output logic                                mem_rd_req,
  output logic [dcache_pkg::ADDR_W-1:0]       mem_rd_addr,
  output logic                                mem_wr,
  output logic [dcache_pkg::ADDR_W-1:0]       mem_wr_addr,
  output logic [dcache_pkg::XLEN-1:0]         mem_wr_data,
  output logic [dcache_pkg::XLEN/8-1:0]       mem_wr_mask,
  output logic                                ld_valid,
  output logic [8*dcache_pkg::LINE_BYTES-1:0] ld_line,
  output dcache_pkg::dec_req_t                ld_req
);

  localparam int ADDR_W = dcache_pkg::ADDR_W;
  localparam int OFF_W  = dcache_pkg::OFFSET_W;
  localparam int TAG_W  = ADDR_W - INDEX_W - OFF_W;
  localparam int LINES  = 1 << INDEX_W;
  localparam int HALF   = dcache_pkg::LINE_BYTES / 2;

  typedef enum logic [1:0] {
    st_idle,
    st_lookup,
    st_refill,
    st_finish
  } state_e;

  state_e                                state;
  dcache_pkg::dec_req_t                  req_q;
  logic [INDEX_W-1:0]                    cur_index;
  logic [INDEX_W-1:0]                    rd_index;
  logic [TAG_W-1:0]                      cur_tag;
  logic [TAG_W-1:0]                      tag_rd;
  logic                                  valid_rd;
  logic                                  hit;
  logic                                  wr_line;
  logic                                  wr_bytes;
  logic [8*dcache_pkg::LINE_BYTES-1:0]   line_rd;
  logic [TAG_W-1:0]                      tag_mem [LINES];
  logic [LINES-1:0]                      valid_bits;

  assign cur_index = req_q.addr[OFF_W +: INDEX_W];
  assign cur_tag   = req_q.addr[ADDR_W-1 -: TAG_W];
  // new request reads the arrays while it is being latched
  assign rd_index  = dec_valid ? dec_req.addr[OFF_W +: INDEX_W] : cur_index;

  assign hit      = valid_rd && (tag_rd == cur_tag);
  assign wr_line  = (state == st_refill) && mem_rd_valid;
  assign wr_bytes = (state == st_lookup) && req_q.we && hit;

  // decode output covers the cycle before the FSM leaves idle
  assign busy = dec_valid || (state != st_idle);

  assign mem_rd_addr = {req_q.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign mem_wr_addr = {req_q.addr[ADDR_W-1:3], 3'b000};
  assign mem_wr_data = req_q.lane_data;
  assign mem_wr_mask = req_q.offset[OFF_W-1] ? req_q.mask[2*HALF-1:HALF] : req_q.mask[HALF-1:0];
  assign ld_req      = req_q;

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      req_q <= dec_req;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_line) begin
      tag_mem[cur_index] <= cur_tag;
    end
    tag_rd   <= tag_mem[rd_index];
    valid_rd <= valid_bits[rd_index];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
    end else if (wr_line) begin
      valid_bits[cur_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      ld_valid   <= 1'b0;
      mem_rd_req <= 1'b0;
      mem_wr     <= 1'b0;
    end else begin
      ld_valid   <= 1'b0;
      mem_rd_req <= 1'b0;
      mem_wr     <= 1'b0;
      case (state)
        st_idle: begin
          if (dec_valid) state <= st_lookup;
        end
        st_lookup: begin
          if (req_q.we) begin  // write-through, no allocate
            mem_wr <= 1'b1;
            state  <= st_finish;
          end else if (hit) begin
            ld_valid <= 1'b1;
            state    <= st_finish;
          end else begin
            mem_rd_req <= 1'b1;
            state      <= st_refill;
          end
        end
        st_refill: begin
          if (mem_rd_valid) begin
            ld_valid <= 1'b1;
            state    <= st_finish;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // line handed to the result stage
  always_ff @(posedge clk) begin
    if (wr_line) begin
      ld_line <= mem_rd_line;  // bypass, array read is one edge behind
    end else if (state == st_lookup && hit) begin
      ld_line <= line_rd;
    end
  end

  dcache_data #(
    .INDEX_W (INDEX_W)
  ) u_data (
    .clk       (clk),
    .wr_line   (wr_line),
    .wr_bytes  (wr_bytes),
    .index     (rd_index),
    .mask      (req_q.mask),
    .lane_data (req_q.lane_data),
    .line_in   (mem_rd_line),
    .line_out  (line_rd)
  );

endmodule

// File: source/dcache_data.sv
`timescale 1ns/1ps

module dcache_data #(
  parameter int INDEX_W = 6
) (
  input  logic                                 clk,
  input  logic                                 wr_line,    // refill
  input  logic                                 wr_bytes,   // store hit
  input  logic [INDEX_W-1:0]                   index,
  input  logic [dcache_pkg::LINE_BYTES-1:0]    mask,
  input  logic [dcache_pkg::XLEN-1:0]          lane_data,
  input  logic [8*dcache_pkg::LINE_BYTES-1:0]  line_in,
  output logic [8*dcache_pkg::LINE_BYTES-1:0]  line_out
);

  localparam int NB    = dcache_pkg::LINE_BYTES;
  localparam int LINES = 1 << INDEX_W;
  localparam int LANES = dcache_pkg::XLEN / 8;

  // one byte-wide RAM per line byte, so a store touches only its lanes
  for (genvar b = 0; b < NB; b++) begin : g_byte
    logic [7:0] mem [LINES];
    logic [7:0] rd_q;

    always_ff @(posedge clk) begin
      if (wr_line) begin
        mem[index] <= line_in[8*b +: 8];
      end else if (wr_bytes && mask[b]) begin
        // upper half of the line reuses the same 8 lanes
        mem[index] <= lane_data[8*(b % LANES) +: 8];
      end
    end

    // old contents on a same-edge write
    always_ff @(posedge clk) begin
      rd_q <= mem[index];
    end

    assign line_out[8*b +: 8] = rd_q;
  end

endmodule

// File: source/dcache_decode.sv
`timescale 1ns/1ps

module dcache_decode #(
  parameter int INDEX_W = 6
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req,
  input  logic                 accept,
  input  dcache_pkg::cpu_req_t cpu_req,
  output logic                 dec_valid,
  output dcache_pkg::dec_req_t dec_req
);

  localparam int OFF_W = dcache_pkg::OFFSET_W;
  localparam int NB    = dcache_pkg::LINE_BYTES;

  logic [OFF_W-1:0]           offset;
  logic [NB-1:0]              mask;
  logic [dcache_pkg::XLEN-1:0] lane_data;
  dcache_pkg::dec_req_t       dec_next;

  // index field must fit the address next to tag and offset
  if (INDEX_W < 2 || INDEX_W > 12) begin : g_bad_index
    $error("dcache_decode: INDEX_W must be between 2 and 12");
  end

  assign offset = cpu_req.addr[OFF_W-1:0];

  // byte b is selected when it sits in the same size-aligned group as the offset
  always_comb begin
    logic [OFF_W-1:0] lane;
    mask = '0;
    for (int b = 0; b < NB; b++) begin
      lane    = OFF_W'(b);
      mask[b] = (lane >> cpu_req.size) == (offset >> cpu_req.size);
    end
  end

  always_comb begin
    case (cpu_req.size)
      dcache_pkg::size_byte: lane_data = {8{cpu_req.wdata[7:0]}};
      dcache_pkg::size_half: lane_data = {4{cpu_req.wdata[15:0]}};
      dcache_pkg::size_word: lane_data = {2{cpu_req.wdata[31:0]}};
      default:               lane_data = cpu_req.wdata;
    endcase
  end

  always_comb begin
    dec_next.we        = cpu_req.we;
    dec_next.size      = cpu_req.size;
    dec_next.uns       = cpu_req.uns;
    dec_next.addr      = cpu_req.addr;
    dec_next.offset    = offset;
    dec_next.mask      = mask;
    dec_next.lane_data = lane_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= req && accept;
    end
  end

  always_ff @(posedge clk) begin
    if (req && accept) begin
      dec_req <= dec_next;
    end
  end

endmodule

// File: source/dcache_pkg.sv
package dcache_pkg;

  localparam int ADDR_W     = 32;
  localparam int LINE_BYTES = 16;
  localparam int OFFSET_W   = 4;   // log2 of LINE_BYTES
  localparam int XLEN       = 64;

  // access width, same encoding as the core's store source field
  typedef enum logic [1:0] {
    size_byte   = 2'b00,
    size_half   = 2'b01,
    size_word   = 2'b10,
    size_double = 2'b11
  } size_e;

  // request as it arrives from the CPU
  typedef struct packed {
    logic              we;      // store
    size_e             size;
    logic              uns;     // zero extend on load
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
  } cpu_req_t;

  // request after decode, carried through the cache
  typedef struct packed {
    logic                  we;
    size_e                 size;
    logic                  uns;
    logic [ADDR_W-1:0]     addr;
    logic [OFFSET_W-1:0]   offset;
    logic [LINE_BYTES-1:0] mask;       // one bit per line byte
    logic [XLEN-1:0]       lane_data;  // store data copied across lanes
  } dec_req_t;

endpackage
